//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
src/icache_pkg.sv
src/icache_tags.sv
src/icache_data.sv
src/icache_ctrl.sv
src/icache_top.sv
test/icache_asserts.sv
test/tb_icache.sv

//--- src/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
	input  logic                   clock,
	input  logic                   reset,
	input  icache_pkg::fetch_req_t req_i,
	input  logic                   fence_i,
	input  icache_pkg::lookup_t    lookup_i,
	input  icache_pkg::line_t      hit_line_i,
	input  icache_pkg::line_t      fill_line_i,
	input  icache_pkg::mem_beat_t  beat_i,
	output icache_pkg::fetch_rsp_t rsp_o,
	output icache_pkg::mem_req_t   mem_req_o,
	output logic                   fill_o,
	output logic                   invalidate_o
);

	icache_pkg::ctrl_state_e state_q;
	icache_pkg::ctrl_state_e state_d;

	logic [icache_pkg::word_sel_bits-1:0] word_sel;
	logic                                 last_beat;
	icache_pkg::word_t                    hit_word;
	icache_pkg::word_t                    fill_word;

	function automatic icache_pkg::word_t pick_word(input icache_pkg::line_t line,
			input logic [icache_pkg::word_sel_bits-1:0] sel);
		return line[sel * icache_pkg::word_bits +: icache_pkg::word_bits];
	endfunction

	assign word_sel  = req_i.addr.fields.word_sel;
	assign last_beat = beat_i.valid && beat_i.last;
	assign hit_word  = pick_word(hit_line_i, word_sel);
	assign fill_word = pick_word(fill_line_i, word_sel);

	always_comb begin
		state_d      = state_q;
		rsp_o        = '0;
		mem_req_o    = '0;
		fill_o       = 1'b0;
		invalidate_o = 1'b0;

		unique case (state_q)
			icache_pkg::ctrl_idle: begin
				if (req_i.valid) begin
					state_d = lookup_i.hit ? icache_pkg::ctrl_hit : icache_pkg::ctrl_refill;
				end else if (fence_i) begin
					state_d = icache_pkg::ctrl_fence;  // only honoured with no fetch pending
				end
			end

			icache_pkg::ctrl_hit: begin
				rsp_o.ready = 1'b1;
				rsp_o.data  = hit_word;
				state_d     = icache_pkg::ctrl_idle;
			end

			icache_pkg::ctrl_refill: begin
				mem_req_o.valid = 1'b1;
				mem_req_o.addr  = {req_i.addr.raw[icache_pkg::addr_bits-1:icache_pkg::offset_bits],
					{icache_pkg::offset_bits{1'b0}}};
				// answer straight from the assembled line on the closing beat
				if (last_beat) begin
					rsp_o.ready = 1'b1;
					rsp_o.data  = fill_word;
					fill_o      = 1'b1;
					state_d     = icache_pkg::ctrl_idle;
				end
			end

			icache_pkg::ctrl_fence: begin
				invalidate_o = 1'b1;
				state_d      = icache_pkg::ctrl_idle;
			end

			default: begin
				state_d = icache_pkg::ctrl_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= icache_pkg::ctrl_idle;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

`default_nettype wire

//--- src/icache_data.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [icache_pkg::index_bits-1:0] index_i,
	input  icache_pkg::lookup_t               lookup_i,
	input  icache_pkg::mem_beat_t             beat_i,
	input  logic                              fill_i,
	output icache_pkg::line_t                 hit_line_o,
	output icache_pkg::line_t                 fill_line_o
);

	icache_pkg::line_t asm_q;  // refill assembly, newest beat enters at the top
	icache_pkg::line_t way_line [icache_pkg::num_ways];

	// line as it will look once the current beat is taken
	assign fill_line_o = {beat_i.data, asm_q[icache_pkg::line_bits-1:icache_pkg::word_bits]};

	always_ff @(posedge clock) begin
		if (reset) begin
			asm_q <= '0;
		end else if (beat_i.valid) begin
			asm_q <= fill_line_o;
		end
	end

	// one storage array per way, written only when it is the refill way
	for (genvar w = 0; w < icache_pkg::num_ways; w++) begin : g_way
		icache_pkg::line_t mem [icache_pkg::num_sets];
		logic              we;

		assign we = fill_i && (lookup_i.fill_way == icache_pkg::way_t'(w));

		always_ff @(posedge clock) begin
			if (we) begin
				mem[index_i] <= fill_line_o;
			end
		end

		assign way_line[w] = mem[index_i];
	end

	assign hit_line_o = way_line[lookup_i.hit_way];

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

	localparam int addr_bits      = 32;
	localparam int word_bits      = 32;
	localparam int offset_bits    = 4;   // byte offset within a line
	localparam int index_bits     = 8;
	localparam int tag_bits       = addr_bits - index_bits - offset_bits;
	localparam int num_ways       = 4;
	localparam int num_sets       = 1 << index_bits;
	localparam int beats_per_line = 4;
	localparam int line_bits      = beats_per_line * word_bits;
	localparam int way_bits       = $clog2(num_ways);
	localparam int word_sel_bits  = $clog2(beats_per_line);
	localparam int byte_sel_bits  = offset_bits - word_sel_bits;

	typedef logic [word_bits-1:0] word_t;
	typedef logic [line_bits-1:0] line_t;  // word 0 in the low bits
	typedef logic [way_bits-1:0]  way_t;

	// flat address for fetch and burst, split fields for tag and word lookup
	typedef union packed {
		logic [addr_bits-1:0] raw;
		struct packed {
			logic [tag_bits-1:0]      tag;
			logic [index_bits-1:0]    index;
			logic [word_sel_bits-1:0] word_sel;
			logic [byte_sel_bits-1:0] byte_sel;
		} fields;
	} fetch_addr_u;

	typedef struct packed {
		logic        valid;
		fetch_addr_u addr;
	} fetch_req_t;

	typedef struct packed {
		logic  ready;
		word_t data;
	} fetch_rsp_t;

	typedef struct packed {
		logic                 valid;
		logic [addr_bits-1:0] addr;  // line aligned
	} mem_req_t;

	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} mem_beat_t;

	typedef struct packed {
		logic hit;
		way_t hit_way;
		way_t fill_way;
	} lookup_t;

	typedef enum logic [1:0] {
		ctrl_idle   = 2'd0,
		ctrl_hit    = 2'd1,
		ctrl_refill = 2'd2,
		ctrl_fence  = 2'd3
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- src/icache_tags.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tags (
	input  logic                    clock,
	input  logic                    reset,
	input  icache_pkg::fetch_addr_u addr_i,
	input  logic                    fill_i,
	input  logic                    invalidate_i,
	output icache_pkg::lookup_t     lookup_o
);

	logic [icache_pkg::tag_bits-1:0] tag_mem [icache_pkg::num_sets][icache_pkg::num_ways];
	logic [icache_pkg::num_ways-1:0] valid_q [icache_pkg::num_sets];

	icache_pkg::way_t                victim_q;  // free running, used once the set is full
	logic [icache_pkg::num_ways-1:0] set_valid;
	logic [icache_pkg::num_ways-1:0] way_hit;
	logic [icache_pkg::index_bits-1:0] index;
	logic [icache_pkg::tag_bits-1:0]   tag;

	assign index     = addr_i.fields.index;
	assign tag       = addr_i.fields.tag;
	assign set_valid = valid_q[index];

	// compare all ways of the indexed set at once
	always_comb begin
		for (int w = 0; w < icache_pkg::num_ways; w++) begin
			way_hit[w] = set_valid[w] && (tag_mem[index][w] == tag);
		end
	end

	always_comb begin
		lookup_o.hit      = |way_hit;
		lookup_o.hit_way  = '0;
		lookup_o.fill_way = victim_q;
		// walk downwards so the lowest matching way wins
		for (int w = icache_pkg::num_ways - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				lookup_o.hit_way = icache_pkg::way_t'(w);
			end
			if (!set_valid[w]) begin
				lookup_o.fill_way = icache_pkg::way_t'(w);  // empty way before eviction
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			victim_q <= '0;
		end else begin
			victim_q <= victim_q + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || invalidate_i) begin
			for (int s = 0; s < icache_pkg::num_sets; s++) begin
				valid_q[s] <= '0;
			end
		end else if (fill_i) begin
			valid_q[index][lookup_o.fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_i) begin
			tag_mem[index][lookup_o.fill_way] <= tag;
		end
	end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
	input  logic                   clock,
	input  logic                   reset,
	input  icache_pkg::fetch_req_t fetch_req_i,
	output icache_pkg::fetch_rsp_t fetch_rsp_o,
	input  logic                   fence_i,
	output icache_pkg::mem_req_t   mem_req_o,
	input  icache_pkg::mem_beat_t  mem_beat_i
);

	icache_pkg::lookup_t lookup;
	icache_pkg::line_t   hit_line;
	icache_pkg::line_t   fill_line;
	logic                fill;        // last beat accepted, tags and data write together
	logic                invalidate;

	icache_tags u_tags (
		.clock        (clock),
		.reset        (reset),
		.addr_i       (fetch_req_i.addr),
		.fill_i       (fill),
		.invalidate_i (invalidate),
		.lookup_o     (lookup)
	);

	icache_data u_data (
		.clock       (clock),
		.reset       (reset),
		.index_i     (fetch_req_i.addr.fields.index),
		.lookup_i    (lookup),
		.beat_i      (mem_beat_i),
		.fill_i      (fill),
		.hit_line_o  (hit_line),
		.fill_line_o (fill_line)
	);

	icache_ctrl u_ctrl (
		.clock        (clock),
		.reset        (reset),
		.req_i        (fetch_req_i),
		.fence_i      (fence_i),
		.lookup_i     (lookup),
		.hit_line_i   (hit_line),
		.fill_line_i  (fill_line),
		.beat_i       (mem_beat_i),
		.rsp_o        (fetch_rsp_o),
		.mem_req_o    (mem_req_o),
		.fill_o       (fill),
		.invalidate_o (invalidate)
	);

endmodule

`default_nettype wire

//--- test/icache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module icache_asserts (
	input logic                   clock,
	input logic                   reset,
	input icache_pkg::fetch_rsp_t fetch_rsp_i,
	input icache_pkg::mem_req_t   mem_req_i,
	input icache_pkg::mem_beat_t  mem_beat_i
);

	logic last_beat;

	assign last_beat = mem_beat_i.valid && mem_beat_i.last;

	ready_one_cycle: assert property (@(posedge clock) disable iff (reset)
		fetch_rsp_i.ready |=> !fetch_rsp_i.ready)
		else $error("fetch ready stayed high for more than one cycle");

	// request and its address stay put until the closing beat
	req_held: assert property (@(posedge clock) disable iff (reset)
		mem_req_i.valid && !last_beat |=> mem_req_i.valid && $stable(mem_req_i.addr))
		else $error("burst request dropped or changed before the last beat");

	req_aligned: assert property (@(posedge clock) disable iff (reset)
		mem_req_i.valid |-> mem_req_i.addr[icache_pkg::offset_bits-1:0] == '0)
		else $error("burst address is not line aligned");

	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !fetch_rsp_i.ready && !mem_req_i.valid)
		else $error("ready or burst request active right after reset");

endmodule

`default_nettype wire

//--- test/icache_golden.txt
# op addr word miss, all hex
# op 0 is a fetch, op 1 a fence; miss 1 means a burst is expected
0 00000100 5a5a0100 1
0 00001104 5a5a1104 1
0 00002108 5a5a2108 1
0 0000310c 5a5a310c 1
0 0000010c 5a5a010c 0
0 00001100 5a5a1100 0
0 00002104 5a5a2104 0
0 00003108 5a5a3108 0
0 00004104 5a5a4104 1
0 00004108 5a5a4108 0
0 00000a30 5a5a0a30 1
0 00000a3c 5a5a0a3c 0
1 00000000 00000000 0
0 00000100 5a5a0100 1
0 00001108 5a5a1108 1
0 00004100 5a5a4100 1
0 00000a34 5a5a0a34 1
0 0000410c 5a5a410c 0

//--- test/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

	logic                   clock;
	logic                   reset;
	icache_pkg::fetch_req_t fetch_req;
	icache_pkg::fetch_rsp_t fetch_rsp;
	logic                   fence;
	icache_pkg::mem_req_t   mem_req;
	icache_pkg::mem_beat_t  mem_beat;

	icache_top u_icache_top (
		.clock       (clock),
		.reset       (reset),
		.fetch_req_i (fetch_req),
		.fetch_rsp_o (fetch_rsp),
		.fence_i     (fence),
		.mem_req_o   (mem_req),
		.mem_beat_i  (mem_beat)
	);

	bind icache_top icache_asserts u_asserts (
		.clock       (clock),
		.reset       (reset),
		.fetch_rsp_i (fetch_rsp_o),
		.mem_req_i   (mem_req_o),
		.mem_beat_i  (mem_beat_i)
	);

	always #20 clock = ~clock;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input icache_pkg::word_t got,
			input icache_pkg::word_t expected);
		if (got !== expected) begin
			stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
		end
	endtask

	task automatic check_miss(input string name, input bit got, input bit expected);
		if (got !== expected) begin
			stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
		end
	endtask

	task automatic check_addr(input string name,
			input logic [icache_pkg::addr_bits-1:0] got,
			input logic [icache_pkg::addr_bits-1:0] expected);
		if (got !== expected) begin
			stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
		end
	endtask

	// memory contents: the word address xor a fixed pattern
	function automatic icache_pkg::word_t mem_word(input logic [31:0] word_addr);
		return word_addr ^ 32'h5a5a0000;
	endfunction

	// four beats lowest word first, 0 to 3 idle cycles before each beat
	task automatic serve_burst(input logic [31:0] line_addr);
		int gap;
		for (int i = 0; i < 4; i++) begin
			gap = int'($urandom % 4);
			repeat (gap) begin
				@(posedge clock);
				#1 mem_beat = '0;
			end
			@(posedge clock);
			#1;
			mem_beat.valid = 1'b1;
			mem_beat.last  = (i == 3);
			mem_beat.data  = mem_word(line_addr + 32'(4 * i));
			@(negedge clock);
			if (!mem_req.valid) begin
				stop_run("burst request dropped before the last beat");
			end
		end
	endtask

	task automatic run_fetch(input logic [31:0] addr, output icache_pkg::word_t data,
			output bit miss);
		int waited;
		waited = 0;
		miss = 1'b0;
		fetch_req.valid    = 1'b1;
		fetch_req.addr.raw = addr;
		@(negedge clock);
		while (!fetch_rsp.ready && !mem_req.valid) begin
			waited++;
			if (waited > 200) begin
				stop_run($sformatf("fetch of %h saw no ready and no burst within 200 cycles",
					addr));
			end
			@(negedge clock);
		end
		if (mem_req.valid) begin
			miss = 1'b1;  // burst requested, so this fetch missed
			check_addr("mem_req.addr", mem_req.addr, addr & 32'hffff_fff0);
			serve_burst(mem_req.addr);
			if (!fetch_rsp.ready) begin
				stop_run($sformatf("fetch of %h got no ready with the last beat", addr));
			end
		end
		data = fetch_rsp.data;
		@(posedge clock);
		#1;
		fetch_req = '0;
		mem_beat  = '0;
	endtask

	task automatic run_fence();
		fence = 1'b1;
		@(posedge clock);
		#1 fence = 1'b0;
		@(posedge clock);  // fence state, valid bits clear here
		#1;
	endtask

	initial begin
		int                fd;
		int                fields;
		int                count;
		string             text;
		logic [31:0]       op;
		logic [31:0]       addr;
		logic [31:0]       exp_word;
		logic [31:0]       exp_miss;
		icache_pkg::word_t got_word;
		bit                got_miss;

		clock     = 1'b0;
		reset     = 1'b1;
		fetch_req = '0;
		fence     = 1'b0;
		mem_beat  = '0;
		void'($urandom(32'hfb11));
		count     = 0;

		fd = $fopen("test/icache_golden.txt", "r");
		if (fd == 0) begin
			stop_run("could not open test/icache_golden.txt");
		end

		repeat (4) @(posedge clock);
		#1 reset = 1'b0;

		while (!$feof(fd)) begin
			text = "";
			void'($fgets(text, fd));
			fields = $sscanf(text, "%h %h %h %h", op, addr, exp_word, exp_miss);
			if (fields == 4) begin  // comment and blank lines fall through
				count++;
				if (op == 32'd1) begin
					run_fence();
				end else begin
					run_fetch(addr, got_word, got_miss);
					check_word($sformatf("fetch_rsp.data at %h", addr), got_word, exp_word);
					check_miss($sformatf("mem_req.valid seen at %h", addr), got_miss,
						exp_miss[0]);
				end
			end
		end
		$fclose(fd);

		if (count == 0) begin
			stop_run("golden file holds no operations");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
